/* Makefile */
# Verilator build and run of the Huffman codebook testbench

VERILATOR ?= verilator
TOP       ?= huff_codebook_tb
FILELIST  ?= huff_codebook_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

/* huff_codebook_top.f */
hw/huff_tree_pkg.sv
hw/huff_code_pkg.sv
hw/htree_store.sv
hw/cb_walker.sv
hw/cw_fifo.sv
hw/code_table.sv
hw/huff_codebook_top.sv
testbench/huff_codebook_tb.sv

/* hw/cb_walker.sv */
module cb_walker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  huff_tree_pkg::node_index_t  root_index,
  output huff_tree_pkg::node_index_t  rd_addr,
  input  huff_tree_pkg::node_t        rd_node,
  output logic                       push,
  input  logic                       full,
  output huff_code_pkg::char_t        cw_char,
  output huff_code_pkg::code_t        cw_code,
  output huff_code_pkg::code_len_t    cw_len,
  output logic                       busy
);

  import huff_tree_pkg::*;
  import huff_code_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DESCEND,
    EMIT,
    BACKTRACK,
    RETRACE
  } walk_state_t;

  walk_state_t state;
  node_index_t addr_q;     // node being read from the store
  node_index_t root_q;     // root captured at start
  code_t       path;       // moves from the root to the current node
  code_len_t   depth;      // number of valid bits in path
  logic        side;       // 0 while the left child is examined
  logic        to_retrace; // where FETCH hands over to
  code_len_t   step;       // moves already replayed during RETRACE

  child_t      child;
  logic        child_is_null;
  logic        child_is_node;
  logic        child_is_leaf;
  code_len_t   trace_idx;
  child_t      trace_child;

  assign child         = side ? rd_node.right : rd_node.left;
  assign child_is_null = (child == NULL_CHILD);
  assign child_is_node = !child_is_null && child[CHILD_NODE_BIT];
  assign child_is_leaf = !child[CHILD_NODE_BIT];

  // replay starts at the first move which is the top used bit of path
  assign trace_idx   = depth - step - 5'd1;
  assign trace_child = path[trace_idx[3:0]] ? rd_node.right : rd_node.left;

  assign rd_addr = addr_q;
  assign busy    = (state != IDLE);
  assign push    = (state == EMIT) && !full; // stall here while the FIFO is full

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= IDLE;
      addr_q     <= '0;
      path       <= '0;
      depth      <= '0;
      side       <= 1'b0;
      to_retrace <= 1'b0;
      step       <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            addr_q     <= root_index;
            path       <= '0;
            depth      <= '0;
            side       <= 1'b0;
            to_retrace <= 1'b0;
            state      <= FETCH;
          end
        end
        FETCH: begin
          state <= to_retrace ? RETRACE : DESCEND; // read data is valid in the next state
        end
        DESCEND: begin
          if (child_is_null) begin
            if (side) begin
              state <= BACKTRACK;
            end else begin
              side <= 1'b1; // skip a missing left child
            end
          end else if (child_is_node) begin
            path   <= {path[MAX_CODE_LEN-2:0], side};
            depth  <= depth + 5'd1;
            addr_q <= child[NODE_IDX_W-1:0];
            side   <= 1'b0;
            state  <= FETCH;
          end else begin
            state <= EMIT;
          end
        end
        EMIT: begin
          if (!full) begin
            if (side) begin
              state <= BACKTRACK;
            end else begin
              side  <= 1'b1; // the right child of the same node is next
              state <= DESCEND;
            end
          end
        end
        BACKTRACK: begin
          if (depth == '0) begin
            state <= IDLE; // both subtrees of the root are done
          end else begin
            path  <= path >> 1;
            depth <= depth - 5'd1;
            if (!path[0]) begin
              // the left move turns into a right move from the parent
              addr_q     <= root_q;
              step       <= '0;
              to_retrace <= 1'b1;
              state      <= FETCH;
            end
          end
        end
        RETRACE: begin
          if (step == depth) begin
            side       <= 1'b1; // parent reached so look at its right child
            to_retrace <= 1'b0;
            state      <= DESCEND;
          end else begin
            addr_q <= trace_child[NODE_IDX_W-1:0];
            step   <= step + 5'd1;
            state  <= FETCH;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      root_q <= root_index;
    end
    if (state == DESCEND && child_is_leaf) begin
      cw_char <= child[7:0];
      cw_code <= {path[MAX_CODE_LEN-2:0], side};
      cw_len  <= depth + 5'd1;
    end
  end

  // an internal node at depth 15 already puts its leaves at the 16 bit limit
  a_depth_bound: assert property (
    @(posedge clk) disable iff (rst)
    state == DESCEND && child_is_node |-> depth < code_len_t'(MAX_CODE_LEN - 1)
  ) else $error("cb_walker: tree deeper than %0d levels", MAX_CODE_LEN);

endmodule

/* hw/code_table.sv */
module code_table (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    cw_req,
  input  huff_code_pkg::char_t     cw_char,
  input  huff_code_pkg::code_t     cw_code,
  input  huff_code_pkg::code_len_t cw_len,
  output logic                    cw_ack,
  input  huff_code_pkg::char_t     lookup_char,
  output huff_code_pkg::code_t     lookup_code,
  output huff_code_pkg::code_len_t lookup_len,
  output logic                    lookup_valid
);

  import huff_code_pkg::*;

  code_t              code_mem [NUM_CHARS];
  code_len_t          len_mem  [NUM_CHARS];
  logic [NUM_CHARS-1:0] valid;
  logic               wr_en;

  // one write per request since ack stays high until req falls
  assign wr_en = cw_req && !cw_ack;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      code_mem[cw_char] <= cw_code;
      len_mem[cw_char]  <= cw_len;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cw_ack       <= 1'b0;
      valid        <= '0;
      lookup_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        cw_ack <= 1'b1;
      end else if (!cw_req && cw_ack) begin
        cw_ack <= 1'b0; // FIFO has popped and released req
      end
      if (clear) begin
        valid <= '0; // a new walk starts from an empty table
      end else if (wr_en) begin
        valid[cw_char] <= 1'b1;
      end
      lookup_valid <= valid[lookup_char];
    end
  end

  always_ff @(posedge clk) begin
    lookup_code <= code_mem[lookup_char];
    lookup_len  <= len_mem[lookup_char];
  end

  // the FIFO holds its request until the table has answered it
  a_req_held_until_ack: assert property (
    @(posedge clk) disable iff (rst)
    cw_req && !cw_ack |=> cw_req
  ) else $error("code_table: req dropped before ack");

endmodule

/* hw/cw_fifo.sv */
module cw_fifo #(
  parameter int DEPTH = huff_code_pkg::CW_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  huff_code_pkg::char_t     cw_char,
  input  huff_code_pkg::code_t     cw_code,
  input  huff_code_pkg::code_len_t cw_len,
  output logic                    full,
  output logic                    cw_req,
  input  logic                    cw_ack,
  output huff_code_pkg::char_t     out_char,
  output huff_code_pkg::code_t     out_code,
  output huff_code_pkg::code_len_t out_len,
  output logic                    empty
);

  import huff_code_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [CW_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign pop   = cw_req && cw_ack; // exactly one pop per acknowledged request

  assign {out_char, out_code, out_len} = mem[rd_ptr]; // head stays put while req is high

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {cw_char, cw_code, cw_len};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      cw_req <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // a fresh request waits until the table has dropped its ack
      if (pop) begin
        cw_req <= 1'b0;
      end else if (!cw_req && !cw_ack && !empty) begin
        cw_req <= 1'b1;
      end
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    push |-> !full
  ) else $error("cw_fifo: push while full");

endmodule

/* hw/htree_store.sv */
module htree_store (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load_req,
  input  huff_tree_pkg::node_index_t load_addr,
  input  huff_tree_pkg::node_t       load_node,
  output logic                      load_ack,
  input  huff_tree_pkg::node_index_t rd_addr,
  output huff_tree_pkg::node_t       rd_node
);

  import huff_tree_pkg::*;

  node_t mem [NUM_NODES];
  logic  load_we;

  // a new request is taken only while ack is still low
  assign load_we = load_req && !load_ack;

  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_node;
    end
    rd_node <= mem[rd_addr]; // walker sees the node one cycle after the address
  end

  // load side of the four-phase handshake
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      load_ack <= 1'b0;
    end else if (load_we) begin
      load_ack <= 1'b1; // raised on the same edge as the write
    end else if (!load_req && load_ack) begin
      load_ack <= 1'b0; // master has released req
    end
  end

  // the master keeps the address on the bus until it drops req
  // otherwise the written slot and the acknowledged slot differ
  a_load_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    load_req && !load_ack |=> !load_req || $stable(load_addr)
  ) else $error("htree_store: load_addr changed during a load request");

endmodule

/* hw/huff_code_pkg.sv */
package huff_code_pkg;

  // longest code the table can hold
  localparam int MAX_CODE_LEN = 16;

  // path bits are right aligned and the first move is the top used bit
  typedef logic [MAX_CODE_LEN-1:0] code_t;

  typedef logic [4:0] code_len_t;

  typedef logic [7:0] char_t;

  localparam int NUM_CHARS = 256;

  // packed codeword {char, code, len}
  localparam int CW_WIDTH = $bits(char_t) + $bits(code_t) + $bits(code_len_t);

  localparam int CW_FIFO_DEPTH = 4;

endpackage

/* hw/huff_codebook_top.sv */
module huff_codebook_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load_req,
  input  huff_tree_pkg::node_index_t  load_addr,
  input  huff_tree_pkg::node_t        load_node,
  output logic                       load_ack,
  input  huff_tree_pkg::node_index_t  root_index,
  input  logic                       start,
  input  huff_code_pkg::char_t        lookup_char,
  output huff_code_pkg::code_t        lookup_code,
  output huff_code_pkg::code_len_t    lookup_len,
  output logic                       lookup_valid,
  output logic                       done
);

  import huff_tree_pkg::*;
  import huff_code_pkg::*;

  node_index_t rd_addr;
  node_t       rd_node;
  logic        push;
  logic        full;
  logic        busy;
  char_t       w_char;
  code_t       w_code;
  code_len_t   w_len;
  logic        cw_req;
  logic        cw_ack;
  char_t       t_char;
  code_t       t_code;
  code_len_t   t_len;
  logic        fifo_empty;
  logic        walk_start;
  logic        armed;      // set once the first walk has been started

  assign walk_start = start && !busy; // the walker ignores start while busy as well

  htree_store u_store (
    .clk       (clk),
    .rst       (rst),
    .load_req  (load_req),
    .load_addr (load_addr),
    .load_node (load_node),
    .load_ack  (load_ack),
    .rd_addr   (rd_addr),
    .rd_node   (rd_node)
  );

  cb_walker u_walker (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .root_index (root_index),
    .rd_addr    (rd_addr),
    .rd_node    (rd_node),
    .push       (push),
    .full       (full),
    .cw_char    (w_char),
    .cw_code    (w_code),
    .cw_len     (w_len),
    .busy       (busy)
  );

  cw_fifo #(
    .DEPTH (CW_FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .cw_char  (w_char),
    .cw_code  (w_code),
    .cw_len   (w_len),
    .full     (full),
    .cw_req   (cw_req),
    .cw_ack   (cw_ack),
    .out_char (t_char),
    .out_code (t_code),
    .out_len  (t_len),
    .empty    (fifo_empty)
  );

  code_table u_table (
    .clk          (clk),
    .rst          (rst),
    .clear        (walk_start),
    .cw_req       (cw_req),
    .cw_char      (t_char),
    .cw_code      (t_code),
    .cw_len       (t_len),
    .cw_ack       (cw_ack),
    .lookup_char  (lookup_char),
    .lookup_code  (lookup_code),
    .lookup_len   (lookup_len),
    .lookup_valid (lookup_valid)
  );

  // done waits for the walker, the FIFO and the link to drain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done  <= 1'b0;
      armed <= 1'b0;
    end else if (walk_start) begin
      done  <= 1'b0;
      armed <= 1'b1;
    end else if (armed && !busy && fifo_empty && !cw_ack) begin
      done <= 1'b1;
    end
  end

endmodule

/* hw/huff_tree_pkg.sv */
package huff_tree_pkg;

  // node store geometry
  localparam int NUM_NODES = 128;
  localparam int NODE_IDX_W = 7;

  typedef logic [NODE_IDX_W-1:0] node_index_t;

  // child reference
  // bit 8 set marks an internal node whose index sits in the low 7 bits
  // bit 8 clear marks a leaf whose character sits in the low 8 bits
  typedef logic [8:0] child_t;

  localparam int CHILD_NODE_BIT = 8;

  // marker for a missing child (bit 8 set with a non-index pattern)
  localparam child_t NULL_CHILD = 9'b110000000;

  // one tree node with the left child in the upper half
  typedef struct packed {
    child_t left;
    child_t right;
  } node_t;

endpackage

/* testbench/codebook_tests.txt */
# test <name>, nodes <n> then (addr left right), root <addr>, expect <n> then (char code len)
# children are 9 bit hex: 1xx internal node xx, 0xx leaf char xx, 180 none; again <name> rewalks
test balanced
nodes 7
00 101 102  01 103 104  02 105 106
03 041 042  04 043 044  05 045 046  06 047 048
root 00
expect 8
41 0 3  42 1 3  43 2 3  44 3 3
45 4 3  46 5 3  47 6 3  48 7 3
test reshaped
nodes 2
00 101 078  01 041 079
root 00
expect 3
41 0 2  79 1 2  78 1 1
test skewed
nodes 16
20 061 121  21 062 122  22 063 123  23 064 124
24 065 125  25 066 126  26 067 127  27 068 128
28 069 129  29 06a 12a  2a 06b 12b  2b 06c 12c
2c 06d 12d  2d 06e 12e  2e 06f 12f  2f 070 071
root 20
expect 17
61 0000 1  62 0002 2  63 0006 3  64 000e 4
65 001e 5  66 003e 6  67 007e 7  68 00fe 8
69 01fe 9  6a 03fe a  6b 07fe b  6c 0ffe c
6d 1ffe d  6e 3ffe e  6f 7ffe f  70 fffe 10
71 ffff 10
again skewed_reload
test single
nodes 1
40 05a 180
root 40
expect 1
5a 0 1

/* testbench/huff_codebook_tb.sv */
module huff_codebook_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import huff_tree_pkg::*;
  import huff_code_pkg::*;

  localparam int    LOAD_TIMEOUT = 20;   // cycles per handshake phase
  localparam int    DONE_TIMEOUT = 4000; // cycles for one whole walk
  localparam string TEST_FILE    = "testbench/codebook_tests.txt";

  logic        clk;
  logic        rst;
  logic        load_req;
  node_index_t load_addr;
  node_t       load_node;
  logic        load_ack;
  node_index_t root_index;
  logic        start;
  char_t       lookup_char;
  code_t       lookup_code;
  code_len_t   lookup_len;
  logic        lookup_valid;
  logic        done;

  string       test_name;
  int          num_nodes;
  node_index_t node_addr  [NUM_NODES]; // tree of the current test
  child_t      node_left  [NUM_NODES];
  child_t      node_right [NUM_NODES];
  node_index_t tree_root;
  logic        exp_known [NUM_CHARS];  // characters that must read valid
  code_t       exp_code  [NUM_CHARS];
  code_len_t   exp_len   [NUM_CHARS];
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  huff_codebook_top dut (
    .clk          (clk),
    .rst          (rst),
    .load_req     (load_req),
    .load_addr    (load_addr),
    .load_node    (load_node),
    .load_ack     (load_ack),
    .root_index   (root_index),
    .start        (start),
    .lookup_char  (lookup_char),
    .lookup_code  (lookup_code),
    .lookup_len   (lookup_len),
    .lookup_valid (lookup_valid),
    .done         (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // inputs change and outputs are sampled 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in test %s: %s", test_name, what);
    errors++;
    timed_out = 1'b1; // the remaining tests are skipped
  endtask

  task automatic write_node(input node_index_t addr, input child_t left, input child_t right);
    int cycles;
    if (timed_out) return;
    load_addr = addr;
    load_node = {left, right};
    load_req  = 1'b1;
    cycles    = 0;
    while (!load_ack && cycles < LOAD_TIMEOUT) begin
      step_cycle();
      cycles++;
    end
    load_req = 1'b0;
    if (!load_ack) begin
      report_timeout($sformatf("load_ack never rose for node %02h", addr));
      return;
    end
    cycles = 0;
    while (load_ack && cycles < LOAD_TIMEOUT) begin
      step_cycle();
      cycles++;
    end
    if (load_ack) report_timeout($sformatf("load_ack never fell for node %02h", addr));
  endtask

  task automatic start_walk();
    int cycles;
    if (timed_out) return;
    root_index = tree_root;
    start      = 1'b1;
    step_cycle();
    start = 1'b0;
    check_value("done after start", 32'(0), 32'(done)); // must fall on the start edge
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      step_cycle();
      cycles++;
    end
    if (!done) report_timeout("done never rose after start");
  endtask

  // every character is looked up and absent ones must read not valid
  task automatic check_table();
    for (int c = 0; c < NUM_CHARS; c++) begin
      lookup_char = char_t'(c);
      step_cycle();
      if (exp_known[c]) begin
        check_value($sformatf("char %02h valid", c), 32'(1), 32'(lookup_valid));
        check_value($sformatf("char %02h code", c), 32'(exp_code[c]), 32'(lookup_code));
        check_value($sformatf("char %02h length", c), 32'(exp_len[c]), 32'(lookup_len));
      end else begin
        check_value($sformatf("char %02h valid", c), 32'(0), 32'(lookup_valid));
      end
    end
  endtask

  task automatic clear_expect();
    for (int c = 0; c < NUM_CHARS; c++) begin
      exp_known[c] = 1'b0;
    end
  endtask

  task automatic finish_test(input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test_name, errors - errors_before);
    end
  endtask

  task automatic run_test();
    int errors_before;
    errors_before = errors;
    for (int i = 0; i < num_nodes; i++) begin
      write_node(node_addr[i], node_left[i], node_right[i]);
    end
    start_walk();
    if (!timed_out) check_table();
    finish_test(errors_before);
  endtask

  initial begin
    int        fd;
    int        n;
    int        got;
    int        errors_before;
    string     kw;
    string     line;
    char_t     rd_char;
    code_t     rd_code;
    code_len_t rd_len;
    rst          = 1'b1;
    load_req     = 1'b0;
    load_addr    = '0;
    load_node    = '0;
    root_index   = '0;
    start        = 1'b0;
    lookup_char  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    num_nodes    = 0;
    tree_root    = '0;
    test_name    = "reset";
    clear_expect();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // nothing has been started yet, so the table must be empty
    errors_before = errors;
    check_table();
    check_value("done", 32'(0), 32'(done)); // still low after many idle cycles
    check_value("load_ack", 32'(0), 32'(load_ack));
    finish_test(errors_before);

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the test file %s", TEST_FILE);
      errors++;
    end else begin
      while (!timed_out && $fscanf(fd, "%s", kw) == 1) begin
        if (kw[0] == "#") begin
          got = $fgets(line, fd); // rest of a comment line
        end else if (kw == "test") begin
          got = $fscanf(fd, "%s", test_name);
          num_nodes = 0;
          clear_expect();
        end else if (kw == "nodes") begin
          got = $fscanf(fd, "%d", num_nodes);
          for (int i = 0; i < num_nodes; i++) begin
            got = $fscanf(fd, "%h %h %h", node_addr[i], node_left[i], node_right[i]);
            if (got != 3) begin
              $display("Malformed node record in test %s", test_name);
              errors++;
            end
          end
        end else if (kw == "root") begin
          got = $fscanf(fd, "%h", tree_root);
        end else if (kw == "expect") begin
          got = $fscanf(fd, "%d", n);
          for (int i = 0; i < n; i++) begin
            got = $fscanf(fd, "%h %h %h", rd_char, rd_code, rd_len);
            if (got != 3) begin
              $display("Malformed expected code in test %s", test_name);
              errors++;
            end
            exp_known[rd_char] = 1'b1;
            exp_code[rd_char]  = rd_code;
            exp_len[rd_char]   = rd_len;
          end
          run_test();
        end else if (kw == "again") begin
          got = $fscanf(fd, "%s", test_name); // same tree written to the same slots
          run_test();
        end else begin
          $display("Unknown keyword %s in the test file", kw);
          errors++;
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 1) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
